// ==== filelist.f ====
hw/radar_pkg.sv
hw/radar_set_decode.sv
hw/radar_timekeeper.sv
hw/radar_core.sv
hw/radar_readback_mux.sv
hw/radar_block.sv
verification/radar_block_tb.sv

// ==== Bender.yml ====
package:
  name: radar_block

dependencies: {}

sources:
  # package first, then leaf modules, then the top level
  - files:
      - hw/radar_pkg.sv
      - hw/radar_set_decode.sv
      - hw/radar_timekeeper.sv
      - hw/radar_core.sv
      - hw/radar_readback_mux.sv
      - hw/radar_block.sv

  - target: test
    files:
      - verification/radar_block_tb.sv

// ==== verification/radar_block_tb.sv ====
/*
 * radar block testbench
 * wishbone register tasks, random correlation runs against a reference sum,
 * time load, completion stamp and pps latch checks
 */

`timescale 1ns/100ps

module radar_block_tb;

  import radar_pkg::*;

  localparam int          NUM_CH         = 2;
  localparam int          MAX_LEN        = 40;
  localparam int          ACK_LIMIT      = 8;
  localparam int          POLL_LIMIT     = 100;
  localparam int          TIMEOUT_CYCLES = 20000;
  localparam logic [31:0] RNG_SEED       = 32'h396d5036;
  // block 3 is unmapped with two channels
  localparam logic [7:0]  MISS_ADDR      = 8'h60;

  logic              ce_clk;
  logic              i_rst_n;
  logic              pps;
  wb_req_t           wb_req;
  wb_rsp_t           o_wb;
  logic [NUM_CH-1:0] rx_stb;
  sample_t           rx_in  [NUM_CH];
  sample_t           ref_in [NUM_CH];

  // sample pairs of the current run
  sample_t           rx_buf  [MAX_LEN];
  sample_t           ref_buf [MAX_LEN];
  int                cycles = 0;
  int                checks = 0;
  int                errors = 0;
  int                tests  = 0;

  radar_block #(.NUM_CHANNELS(NUM_CH)) DUT (
    .ce_clk   (ce_clk),
    .i_rst_n  (i_rst_n),
    .i_wb     (wb_req),
    .o_wb     (o_wb),
    .i_pps    (pps),
    .i_rx_stb (rx_stb),
    .i_rx     (rx_in),
    .i_ref    (ref_in)
  );

  always #4 ce_clk = ~ce_clk;

  // hard stop
  always @(posedge ce_clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout, run did not complete within %0d cycles", TIMEOUT_CYCLES);
      $display("** FAIL **");
      $finish;
    end
  end

  ///////////////////////////////////////////////////////////////////////
  // reference model and helpers
  ///////////////////////////////////////////////////////////////////////
  // sum of rx.i*ref.i + rx.q*ref.q over len pairs
  function automatic logic [ACC_W-1:0] corr_ref(input sample_t rx [MAX_LEN],
                                                input sample_t rf [MAX_LEN],
                                                input int len);
    longint sum;
    sum = 0;
    for (int k = 0; k < len; k++) begin
      sum += longint'($signed(rx[k].i)) * longint'($signed(rf[k].i));
      sum += longint'($signed(rx[k].q)) * longint'($signed(rf[k].q));
    end
    return sum[ACC_W-1:0];
  endfunction

  function automatic logic [7:0] core_addr(input int c, input logic [2:0] r);
    return {3'(c + 1), r, 2'b00};
  endfunction

  function automatic logic [7:0] time_addr(input logic [2:0] r);
    return {3'd0, r, 2'b00};
  endfunction

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_window(input string name, input logic [63:0] val,
                              input logic [63:0] lo, input logic [63:0] hi);
    checks++;
    if (val < lo || val > hi) begin
      errors++;
      $display("[ERROR] %s got %h expected %h to %h", name, val, lo, hi);
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    tests++;
    if (errors == err_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - err_before);
    end
  endtask

  ///////////////////////////////////////////////////////////////////////
  // wishbone single beat accesses
  ///////////////////////////////////////////////////////////////////////
  task automatic wb_access(input logic we, input logic [7:0] addr,
                           input logic [31:0] data, output logic [31:0] rdat);
    int n;
    n = 0;
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: addr, dat: data};
    do begin
      @(posedge ce_clk);
      #1;
      n++;
    end while (!o_wb.ack && n < ACK_LIMIT);
    rdat = o_wb.dat;
    if (!o_wb.ack) begin
      errors++;
      $display("no ack within %0d cycles for access to address %h", ACK_LIMIT, addr);
    end
    wb_req = '0;
    // stb stays low across one edge
    @(posedge ce_clk);
    #1;
  endtask

  task automatic wb_write(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    wb_access(1'b1, addr, data, unused);
  endtask

  task automatic wb_read(input logic [7:0] addr, output logic [31:0] data);
    wb_access(1'b0, addr, '0, data);
  endtask

  // lo read freezes the hi word
  task automatic read_time(input logic [2:0] lo_reg, output logic [63:0] t);
    logic [31:0] lo;
    logic [31:0] hi;
    wb_read(time_addr(lo_reg), lo);
    wb_read(time_addr(lo_reg + 3'd1), hi);
    t = {hi, lo};
  endtask

  ///////////////////////////////////////////////////////////////////////
  // sample stimulus and correlation runs
  ///////////////////////////////////////////////////////////////////////
  task automatic fill_samples(input int len);
    for (int k = 0; k < len; k++) begin
      rx_buf[k]  = sample_t'($urandom);
      ref_buf[k] = sample_t'($urandom);
    end
  endtask

  task automatic drive_samples(input int c, input int len);
    int gap;
    for (int k = 0; k < len; k++) begin
      rx_in[c]  = rx_buf[k];
      ref_in[c] = ref_buf[k];
      rx_stb[c] = 1'b1;
      @(posedge ce_clk);
      #1;
      rx_stb[c] = 1'b0;
      gap = $urandom % 4;
      repeat (gap) begin
        @(posedge ce_clk);
        #1;
      end
    end
  endtask

  task automatic wait_done(input int c);
    logic [31:0] st;
    int          n;
    n = 0;
    do begin
      wb_read(core_addr(c, REG_CTRL), st);
      n++;
    end while (!st[1] && n < POLL_LIMIT);
    if (!st[1]) begin
      errors++;
      $display("channel %0d never reported done after %0d polls", c, POLL_LIMIT);
    end
  endtask

  task automatic check_result(input int c, input int len);
    logic [ACC_W-1:0] exp;
    logic [31:0]      rd;
    exp = corr_ref(rx_buf, ref_buf, len);
    wb_read(core_addr(c, REG_RES_LO), rd);
    check_word($sformatf("ch%0d RES_LO", c), rd, exp[31:0]);
    wb_read(core_addr(c, REG_RES_HI), rd);
    check_word($sformatf("ch%0d RES_HI", c), rd, {{16{exp[ACC_W-1]}}, exp[ACC_W-1:32]});
  endtask

  task automatic run_channel(input int c, input int len);
    fill_samples(len);
    wb_write(core_addr(c, REG_LEN), 32'(len));
    wb_write(core_addr(c, REG_CTRL), 32'h1);
    drive_samples(c, len);
    wait_done(c);
    check_result(c, len);
  endtask

  ///////////////////////////////////////////////////////////////////////
  // main sequence
  ///////////////////////////////////////////////////////////////////////
  initial begin
    logic [31:0] rd;
    logic [31:0] prev_lo;
    logic [31:0] prev_hi;
    logic [63:0] t0;
    logic [63:0] t1;
    logic [63:0] loaded;
    logic [63:0] got;
    int          len;
    int          err0;

    ce_clk  = 1'b0;
    i_rst_n = 1'b0;
    pps     = 1'b0;
    wb_req  = '0;
    rx_stb  = '0;
    for (int c = 0; c < NUM_CH; c++) begin
      rx_in[c]  = '0;
      ref_in[c] = '0;
    end
    void'($urandom(RNG_SEED));
    repeat (10) @(posedge ce_clk);
    #1;
    i_rst_n = 1'b1;
    @(posedge ce_clk);
    #1;

    // reset values and unmapped block
    err0 = errors;
    for (int c = 0; c < NUM_CH; c++) begin
      wb_read(core_addr(c, REG_LEN), rd);
      check_word($sformatf("ch%0d LEN", c), rd, 32'd16);
      wb_read(core_addr(c, REG_CTRL), rd);
      check_word($sformatf("ch%0d CTRL", c), rd, 32'd0);
    end
    wb_write(MISS_ADDR, 32'hdead_beef);
    wb_read(MISS_ADDR, rd);
    check_word("unmapped read", rd, 32'd0);
    report_test("reset values", err0);

    // one random run per channel while the others keep their state
    err0 = errors;
    for (int c = 0; c < NUM_CH; c++) begin
      len = 1 + $urandom % MAX_LEN;
      run_channel(c, len);
      for (int o = 0; o < NUM_CH; o++) begin
        wb_read(core_addr(o, REG_CTRL), rd);
        check_word($sformatf("ch%0d CTRL", o), rd, (o <= c) ? 32'd2 : 32'd0);
      end
    end
    report_test("correlation per channel", err0);

    // idle strobes, re-arm, LEN locked while busy
    err0 = errors;
    wb_read(core_addr(0, REG_RES_LO), prev_lo);
    wb_read(core_addr(0, REG_RES_HI), prev_hi);
    fill_samples(3);
    drive_samples(0, 3);
    wb_read(core_addr(0, REG_RES_LO), rd);
    check_word("ch0 RES_LO after idle strobes", rd, prev_lo);
    wb_read(core_addr(0, REG_RES_HI), rd);
    check_word("ch0 RES_HI after idle strobes", rd, prev_hi);
    len = 1 + $urandom % MAX_LEN;
    fill_samples(len);
    wb_write(core_addr(0, REG_LEN), 32'(len));
    wb_write(core_addr(0, REG_CTRL), 32'h1);
    wb_read(core_addr(0, REG_CTRL), rd);
    check_word("ch0 CTRL busy", rd, 32'd1);
    wb_write(core_addr(0, REG_LEN), 32'(len % MAX_LEN + 1));
    wb_read(core_addr(0, REG_LEN), rd);
    check_word("ch0 LEN while busy", rd, 32'(len));
    wb_read(core_addr(0, REG_RES_LO), rd);
    check_word("ch0 RES_LO after arm", rd, 32'd0);
    wb_read(core_addr(0, REG_RES_HI), rd);
    check_word("ch0 RES_HI after arm", rd, 32'd0);
    drive_samples(0, len);
    wait_done(0);
    check_result(0, len);
    report_test("re-arm and idle strobes", err0);

    // low word wraps between the lo and hi reads
    err0 = errors;
    loaded = 64'h0000_0012_ffff_fffc;
    wb_write(time_addr(TREG_TIME_LO), loaded[31:0]);
    wb_write(time_addr(TREG_TIME_HI), loaded[63:32]);
    read_time(TREG_TIME_LO, got);
    check_window("time after load", got, loaded, loaded + 64'd64);
    report_test("time load and read", err0);

    // stamp and pps inside surrounding time reads
    err0 = errors;
    read_time(TREG_TIME_LO, t0);
    run_channel(NUM_CH - 1, 8);
    read_time(TREG_TIME_LO, t1);
    wb_read(core_addr(NUM_CH - 1, REG_STAMP_LO), rd);
    got[31:0] = rd;
    wb_read(core_addr(NUM_CH - 1, REG_STAMP_HI), rd);
    got[63:32] = rd;
    check_window("completion stamp", got, t0, t1);
    read_time(TREG_TIME_LO, t0);
    pps = 1'b1;
    repeat (4) @(posedge ce_clk);
    #1;
    pps = 1'b0;
    repeat (4) @(posedge ce_clk);
    #1;
    read_time(TREG_TIME_LO, t1);
    read_time(TREG_PPS_LO, got);
    check_window("pps latch", got, t0, t1);
    report_test("stamp and pps", err0);

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== hw/radar_block.sv ====
/*
 * radar block top level
 * wishbone decoder, shared timekeeper, per-channel cores, readback mux
 */

`timescale 1ns/100ps

module radar_block #(
  parameter int NUM_CHANNELS = 2
) (
  input  logic                 ce_clk,
  input  logic                 i_rst_n,
  input  radar_pkg::wb_req_t   i_wb,
  output radar_pkg::wb_rsp_t   o_wb,
  input  logic                 i_pps,
  input  logic [NUM_CHANNELS-1:0] i_rx_stb,
  input  radar_pkg::sample_t   i_rx  [NUM_CHANNELS],
  input  radar_pkg::sample_t   i_ref [NUM_CHANNELS]
);

  import radar_pkg::*;

  // decoded commands, one per unit
  unit_cmd_t         time_cmd;
  unit_cmd_t         core_cmd [NUM_CHANNELS];
  logic              miss;
  // read words back toward the mux
  logic [DATA_W-1:0] time_word;
  logic [DATA_W-1:0] core_word [NUM_CHANNELS];
  // shared time base
  logic [TIME_W-1:0] cur_time;

  radar_set_decode #(.NUM_CHANNELS(NUM_CHANNELS)) u_decode (
    .ce_clk     (ce_clk),
    .i_rst_n    (i_rst_n),
    .i_wb       (i_wb),
    .o_time_cmd (time_cmd),
    .o_core_cmd (core_cmd),
    .o_miss     (miss)
  );

  radar_timekeeper u_timekeeper (
    .ce_clk    (ce_clk),
    .i_rst_n   (i_rst_n),
    .i_pps     (i_pps),
    .i_cmd     (time_cmd),
    .o_rd_word (time_word),
    .o_time    (cur_time)
  );

  ///////////////////////////////////////////////////////////////////////
  // one correlation core per channel
  ///////////////////////////////////////////////////////////////////////
  for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_core
    radar_core u_core (
      .ce_clk    (ce_clk),
      .i_rst_n   (i_rst_n),
      .i_cmd     (core_cmd[c]),
      .i_rx_stb  (i_rx_stb[c]),
      .i_rx      (i_rx[c]),
      .i_ref     (i_ref[c]),
      .i_time    (cur_time),
      .o_rd_word (core_word[c])
    );
  end

  radar_readback_mux #(.NUM_CHANNELS(NUM_CHANNELS)) u_rb_mux (
    .ce_clk      (ce_clk),
    .i_rst_n     (i_rst_n),
    .i_time_cmd  (time_cmd),
    .i_core_cmd  (core_cmd),
    .i_miss      (miss),
    .i_time_word (time_word),
    .i_core_word (core_word),
    .o_wb        (o_wb)
  );

endmodule

// ==== hw/radar_readback_mux.sv ====
/*
 * readback mux
 * ORs unit read words, registers data and the wishbone ack
 */

`timescale 1ns/100ps

module radar_readback_mux #(
  parameter int NUM_CHANNELS = 2
) (
  input  logic                         ce_clk,
  input  logic                         i_rst_n,
  input  radar_pkg::unit_cmd_t         i_time_cmd,
  input  radar_pkg::unit_cmd_t         i_core_cmd [NUM_CHANNELS],
  input  logic                         i_miss,
  input  logic [radar_pkg::DATA_W-1:0] i_time_word,
  input  logic [radar_pkg::DATA_W-1:0] i_core_word [NUM_CHANNELS],
  output radar_pkg::wb_rsp_t           o_wb
);

  import radar_pkg::*;

  logic [DATA_W-1:0] word_or;
  logic              any_stb;
  logic              wr_hit;
  logic              ack_q;
  logic [DATA_W-1:0] dat_q;

  // unaddressed units return 0, so a plain OR selects
  always_comb begin
    word_or = i_time_word;
    any_stb = i_time_cmd.stb || i_miss;
    wr_hit  = i_time_cmd.stb && i_time_cmd.we;
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      word_or = word_or | i_core_word[c];
      any_stb = any_stb || i_core_cmd[c].stb;
      wr_hit  = wr_hit || (i_core_cmd[c].stb && i_core_cmd[c].we);
    end
  end

  always_ff @(posedge ce_clk) begin
    if (!i_rst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= any_stb;
    end
  end

  // write acks carry no data
  always_ff @(posedge ce_clk) begin
    dat_q <= wr_hit ? '0 : word_or;
  end

  assign o_wb = '{dat: dat_q, ack: ack_q};

  // decoder must wait for stb low between accesses
  a_ack_single: assert property (@(posedge ce_clk) disable iff (!i_rst_n)
    ack_q |=> !ack_q);

endmodule

// ==== hw/radar_core.sv ====
/*
 * per-channel radar correlation core
 * armed by CTRL write, sums rx*ref over LEN strobes, latches result and time
 */

`timescale 1ns/100ps

module radar_core (
  input  logic                         ce_clk,
  input  logic                         i_rst_n,
  input  radar_pkg::unit_cmd_t         i_cmd,
  input  logic                         i_rx_stb,
  input  radar_pkg::sample_t           i_rx,
  input  radar_pkg::sample_t           i_ref,
  input  logic [radar_pkg::TIME_W-1:0] i_time,
  output logic [radar_pkg::DATA_W-1:0] o_rd_word
);

  import radar_pkg::*;

  localparam int DEF_LEN = 16;

  core_state_e              state;
  core_reg_e                creg;
  logic [LEN_W-1:0]         len_q;
  logic [LEN_W-1:0]         cnt_q;
  logic signed [ACC_W-1:0]  acc_q;
  logic [TIME_W-1:0]        stamp_q;
  // one complex-conjugate-free real term per strobe
  logic signed [2*SAMPLE_W:0] mac_term;
  logic                     wr;
  logic                     arm;
  logic                     len_wr;
  logic                     take;
  logic                     finish;

  assign creg   = core_reg_e'(i_cmd.reg_sel);
  assign wr     = i_cmd.stb && i_cmd.we;
  assign arm    = wr && creg == REG_CTRL && i_cmd.dat[0];
  // length locked while a run is in flight
  assign len_wr = wr && creg == REG_LEN && state != ST_BUSY;
  assign take   = !arm && state == ST_BUSY && i_rx_stb && cnt_q != len_q;
  assign finish = !arm && state == ST_BUSY && cnt_q == len_q;

  // signed operands widen to 33 bits before the multiply
  assign mac_term = i_rx.i * i_ref.i + i_rx.q * i_ref.q;

  ///////////////////////////////////////////////////////////////////////
  // control
  ///////////////////////////////////////////////////////////////////////
  always_ff @(posedge ce_clk) begin
    if (!i_rst_n) begin
      state <= ST_IDLE;
      len_q <= LEN_W'(DEF_LEN);
      cnt_q <= '0;
    end else begin
      if (len_wr) begin
        len_q <= i_cmd.dat[LEN_W-1:0];
      end
      if (arm) begin
        state <= ST_BUSY;
        cnt_q <= '0;
      end else if (finish) begin
        state <= ST_DONE;
      end else if (take) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  ///////////////////////////////////////////////////////////////////////
  // accumulator and completion stamp
  ///////////////////////////////////////////////////////////////////////
  always_ff @(posedge ce_clk) begin
    if (arm) begin
      acc_q <= '0;
    end else if (take) begin
      acc_q <= acc_q + ACC_W'(mac_term);
    end
    if (finish) begin
      stamp_q <= i_time;
    end
  end

  // register readback, zero unless addressed
  always_comb begin
    o_rd_word = '0;
    if (i_cmd.stb) begin
      case (creg)
        REG_LEN:      o_rd_word = DATA_W'(len_q);
        // bit 1 done, bit 0 busy
        REG_CTRL:     o_rd_word = {30'd0, state == ST_DONE, state == ST_BUSY};
        REG_RES_LO:   o_rd_word = acc_q[DATA_W-1:0];
        REG_RES_HI:   o_rd_word = {{(2*DATA_W-ACC_W){acc_q[ACC_W-1]}},
                                   acc_q[ACC_W-1:DATA_W]};
        REG_STAMP_LO: o_rd_word = stamp_q[DATA_W-1:0];
        REG_STAMP_HI: o_rd_word = stamp_q[TIME_W-1:DATA_W];
        default:      o_rd_word = '0;
      endcase
    end
  end

  // LEN writes are held off while busy, so the count stays bounded
  a_cnt_le_len: assert property (@(posedge ce_clk) disable iff (!i_rst_n)
    state == ST_BUSY |-> cnt_q <= len_q);

endmodule

// ==== hw/radar_timekeeper.sv ====
/*
 * shared timekeeper
 * free-running 64-bit time, host load, snapshot read, pps latch
 */

`timescale 1ns/100ps

module radar_timekeeper (
  input  logic                        ce_clk,
  input  logic                        i_rst_n,
  input  logic                        i_pps,
  input  radar_pkg::unit_cmd_t        i_cmd,
  output logic [radar_pkg::DATA_W-1:0] o_rd_word,
  output logic [radar_pkg::TIME_W-1:0] o_time
);

  import radar_pkg::*;

  logic [TIME_W-1:0] time_q;
  logic [TIME_W-1:0] pps_time_q;
  logic [DATA_W-1:0] lo_stage;
  logic [DATA_W-1:0] hi_snap;
  // pps synchronizer and edge detect
  logic              pps_meta;
  logic              pps_sync;
  logic              pps_prev;
  logic              pps_rise;
  time_reg_e         treg;
  logic              wr;
  logic              rd;

  assign treg     = time_reg_e'(i_cmd.reg_sel);
  assign wr       = i_cmd.stb && i_cmd.we;
  assign rd       = i_cmd.stb && !i_cmd.we;
  assign pps_rise = pps_sync && !pps_prev;

  always_ff @(posedge ce_clk) begin
    if (!i_rst_n) begin
      time_q     <= '0;
      pps_time_q <= '0;
      pps_meta   <= 1'b0;
      pps_sync   <= 1'b0;
      pps_prev   <= 1'b0;
    end else begin
      pps_meta <= i_pps;
      pps_sync <= pps_meta;
      pps_prev <= pps_sync;
      // hi write commits both halves
      if (wr && treg == TREG_TIME_HI) begin
        time_q <= {i_cmd.dat, lo_stage};
      end else begin
        time_q <= time_q + 1'b1;
      end
      if (pps_rise) begin
        pps_time_q <= time_q;
      end
    end
  end

  always_ff @(posedge ce_clk) begin
    if (wr && treg == TREG_TIME_LO) begin
      lo_stage <= i_cmd.dat;
    end
    // hi half frozen with the lo read
    if (rd && treg == TREG_TIME_LO) begin
      hi_snap <= time_q[TIME_W-1:DATA_W];
    end
  end

  always_comb begin
    o_rd_word = '0;
    if (i_cmd.stb) begin
      case (treg)
        TREG_TIME_LO: o_rd_word = time_q[DATA_W-1:0];
        TREG_TIME_HI: o_rd_word = hi_snap;
        TREG_PPS_LO:  o_rd_word = pps_time_q[DATA_W-1:0];
        TREG_PPS_HI:  o_rd_word = pps_time_q[TIME_W-1:DATA_W];
        default:      o_rd_word = '0;
      endcase
    end
  end

  assign o_time = time_q;

endmodule

// ==== hw/radar_set_decode.sv ====
/*
 * wishbone request decoder
 * splits block/register fields, issues one registered unit command per access
 */

`timescale 1ns/100ps

module radar_set_decode #(
  parameter int NUM_CHANNELS = 2
) (
  input  logic                  ce_clk,
  input  logic                  i_rst_n,
  input  radar_pkg::wb_req_t    i_wb,
  output radar_pkg::unit_cmd_t  o_time_cmd,
  output radar_pkg::unit_cmd_t  o_core_cmd [NUM_CHANNELS],
  output logic                  o_miss
);

  import radar_pkg::*;

  // address field positions
  localparam int BLK_LSB = 5;
  localparam int REG_LSB = 2;

  logic                    req;
  logic                    pending;
  logic                    new_acc;
  blk_e                    blk;
  logic [2:0]              chan_idx;
  logic                    chan_hit;
  logic [NUM_CHANNELS-1:0] core_sel;
  // strobes
  logic                    time_stb_q;
  logic [NUM_CHANNELS-1:0] core_stb_q;
  logic                    miss_q;
  // payload shared by all units
  logic                    we_q;
  logic [2:0]              reg_q;
  logic [DATA_W-1:0]       dat_q;

  if (NUM_CHANNELS < 1 || NUM_CHANNELS > MAX_CHANNELS) begin : g_bad_cfg
    $error("NUM_CHANNELS out of range");
  end

  assign req     = i_wb.cyc && i_wb.stb;
  // one command per access, pending holds off until stb drops
  assign new_acc = req && !pending;

  assign blk      = blk_e'(i_wb.adr[ADDR_W-1:BLK_LSB]);
  assign chan_idx = i_wb.adr[ADDR_W-1:BLK_LSB] - BLK_CHAN;
  assign chan_hit = (blk != BLK_TIME) && (int'(chan_idx) < NUM_CHANNELS);

  always_comb begin
    core_sel = '0;
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      core_sel[c] = new_acc && chan_hit && (chan_idx == 3'(c));
    end
  end

  always_ff @(posedge ce_clk) begin
    if (!i_rst_n) begin
      pending    <= 1'b0;
      time_stb_q <= 1'b0;
      core_stb_q <= '0;
      miss_q     <= 1'b0;
    end else begin
      pending    <= req;
      time_stb_q <= new_acc && (blk == BLK_TIME);
      core_stb_q <= core_sel;
      // unmapped channel block
      miss_q     <= new_acc && (blk != BLK_TIME) && !chan_hit;
    end
  end

  always_ff @(posedge ce_clk) begin
    if (new_acc) begin
      we_q  <= i_wb.we;
      reg_q <= i_wb.adr[BLK_LSB-1:REG_LSB];
      dat_q <= i_wb.dat;
    end
  end

  always_comb begin
    o_time_cmd = '{stb: time_stb_q, we: we_q, reg_sel: reg_q, dat: dat_q};
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      o_core_cmd[c] = '{stb: core_stb_q[c], we: we_q, reg_sel: reg_q, dat: dat_q};
    end
  end

  assign o_miss = miss_q;

  // never more than one target per cycle
  a_one_target: assert property (@(posedge ce_clk) disable iff (!i_rst_n)
    $onehot0({time_stb_q, core_stb_q, miss_q}));

endmodule

// ==== hw/radar_pkg.sv ====
/*
 * radar correlation block shared definitions
 * widths, register maps, block select and bus/sample structs
 */

package radar_pkg;

  ///////////////////////////////////////////////////////////////////////
  // widths
  ///////////////////////////////////////////////////////////////////////
  localparam int DATA_W       = 32;
  // byte address, [7:5] block, [4:2] register
  localparam int ADDR_W       = 8;
  localparam int TIME_W       = 64;
  localparam int ACC_W        = 48;
  localparam int LEN_W        = 16;
  localparam int SAMPLE_W     = 16;
  // block 0 is the timekeeper, 1..7 are channels
  localparam int MAX_CHANNELS = 7;

  ///////////////////////////////////////////////////////////////////////
  // address maps
  ///////////////////////////////////////////////////////////////////////
  typedef enum logic [2:0] {
    BLK_TIME = 3'd0,
    // first channel, later channels follow in order
    BLK_CHAN = 3'd1
  } blk_e;

  typedef enum logic [2:0] {
    REG_LEN      = 3'd0,
    REG_CTRL     = 3'd1,
    REG_RES_LO   = 3'd2,
    REG_RES_HI   = 3'd3,
    REG_STAMP_LO = 3'd4,
    REG_STAMP_HI = 3'd5
  } core_reg_e;

  typedef enum logic [2:0] {
    TREG_TIME_LO = 3'd0,
    TREG_TIME_HI = 3'd1,
    TREG_PPS_LO  = 3'd2,
    TREG_PPS_HI  = 3'd3
  } time_reg_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BUSY,
    ST_DONE
  } core_state_e;

  ///////////////////////////////////////////////////////////////////////
  // structs
  ///////////////////////////////////////////////////////////////////////
  // wishbone classic request, single beat
  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic              we;
    logic [ADDR_W-1:0] adr;
    logic [DATA_W-1:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] dat;
    logic              ack;
  } wb_rsp_t;

  // one decoded access toward a single unit
  typedef struct packed {
    logic              stb;
    logic              we;
    logic [2:0]        reg_sel;
    logic [DATA_W-1:0] dat;
  } unit_cmd_t;

  typedef struct packed {
    logic signed [SAMPLE_W-1:0] i;
    logic signed [SAMPLE_W-1:0] q;
  } sample_t;

endpackage
